// ==== common/line_dump_params.svh ====
`ifndef LINE_DUMP_PARAMS_SVH
`define LINE_DUMP_PARAMS_SVH

// bytes per cache line, which gives 128-bit lines
`define LINE_BYTES 16

// line address width, so the store holds 16 lines
`define ADDR_BITS 4

// entries in each stream_buffer
`define BUF_DEPTH 4

// clocks per UART bit, also the uart_tx default
`define CLKS_PER_BIT 8

`endif

// ==== common/line_dump_pkg.sv ====
`include "line_dump_params.svh"

package line_dump_pkg;

	typedef logic [7:0] byte_t;

	// byte 0 of a line sits in the low bits
	typedef logic [`LINE_BYTES-1:0][7:0] line_t;

	typedef struct packed {
		logic                  write;
		logic [`ADDR_BITS-1:0] addr;
		line_t                 data;
	} mem_req_t;

	// write flag comes back from the store so the control knows what finished
	typedef struct packed {
		logic  write;
		line_t data;
	} mem_rsp_t;

endpackage

// ==== design/stream_buffer.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module stream_buffer import line_dump_pkg::*; #(
	parameter type payload_t = byte_t
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	localparam int PTR_W = $clog2(`BUF_DEPTH);
	localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

	payload_t mem [`BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign in_ready = (count != CNT_W'(`BUF_DEPTH));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(`BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module uart_tx import line_dump_pkg::*; #(
	parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  byte_valid,
	output logic  byte_ready,
	input  byte_t byte_in,
	output logic  tx
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic [2:0] bit_idx;
	byte_t shift;
	logic bit_end;

	assign bit_end = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign byte_ready = (state == TX_IDLE);

	// line idles high, start bit low, data lsb first, stop bit high
	always_comb begin
		case (state)
			TX_START: tx = 1'b0;
			TX_DATA: tx = shift[0];
			default: tx = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (byte_valid && byte_ready) begin
			shift <= byte_in;
		end else if (state == TX_DATA && bit_end) begin
			shift <= shift >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			if (state == TX_IDLE || bit_end) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: if (byte_valid) state <= TX_START;
				TX_START: begin
					if (bit_end) begin
						state <= TX_DATA;
						bit_idx <= '0;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) state <= TX_STOP;
						else bit_idx <= bit_idx + 3'd1;
					end
				end
				TX_STOP: if (bit_end) state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// ==== line_ctrl/line_ctrl.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module line_ctrl import line_dump_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  write_req,
	input  logic                  read_req,
	input  logic [`ADDR_BITS-1:0] line_addr,
	output logic                  busy,
	output logic                  req_valid,
	input  logic                  req_ready,
	output mem_req_t              req,
	input  logic                  rsp_valid,
	output logic                  rsp_ready,
	input  mem_rsp_t              rsp,
	output logic                  line_valid,
	input  logic                  line_ready,
	output line_t                 line,
	input  logic                  line_done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT_RSP,
		S_WAIT_DUMP
	} state_t;

	state_t state;
	logic is_write;
	logic [`ADDR_BITS-1:0] addr_q;
	line_t fill_line;
	logic accept;

	assign accept = (state == S_IDLE) && (write_req || read_req);

	// byte k of a written line is the address xor k
	always_comb begin
		for (int k = 0; k < `LINE_BYTES; k++) begin
			fill_line[k] = 8'(addr_q) ^ 8'(k);
		end
	end

	// write wins when both pulses arrive together
	always_ff @(posedge clk) begin
		if (accept) begin
			is_write <= write_req;
			addr_q <= line_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (accept) state <= S_REQ;
				S_REQ: if (req_ready) state <= S_WAIT_RSP;
				S_WAIT_RSP: begin
					if (rsp_valid && rsp_ready) begin
						state <= rsp.write ? S_IDLE : S_WAIT_DUMP;
					end
				end
				S_WAIT_DUMP: if (line_done) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign busy = (state != S_IDLE);

	assign req_valid = (state == S_REQ);
	assign req.write = is_write;
	assign req.addr = addr_q;
	assign req.data = is_write ? fill_line : '0;

	// read lines go straight on to the serializer, the store holds them steady
	assign line_valid = (state == S_WAIT_RSP) && rsp_valid && !rsp.write;
	assign line = rsp.data;
	assign rsp_ready = (state == S_WAIT_RSP) && (rsp.write || line_ready);

endmodule

// ==== line_store/line_store.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module line_store import line_dump_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid,
	output logic     req_ready,
	input  mem_req_t req,
	output logic     rsp_valid,
	input  logic     rsp_ready,
	output mem_rsp_t rsp
);

	localparam int LINES = 1 << `ADDR_BITS;

	line_t mem [LINES];
	logic [7:0] lfsr;
	logic pending;
	logic [1:0] wait_cnt;
	logic rsp_write_q;
	line_t rsp_line_q;

	// one request in flight until its response has gone out
	assign req_ready = !pending;

	assign rsp.write = rsp_write_q;
	assign rsp.data = rsp_line_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= 8'hb5;
			pending <= 1'b0;
			rsp_valid <= 1'b0;
			wait_cnt <= '0;
			for (int i = 0; i < LINES; i++) begin
				mem[i] <= '0;
			end
		end else begin
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
			if (req_valid && req_ready) begin
				pending <= 1'b1;
				// low lfsr bits give a 1 to 4 cycle wait, like a DRAM that is slow to answer
				wait_cnt <= lfsr[1:0];
				rsp_write_q <= req.write;
				if (req.write) begin
					mem[req.addr] <= req.data;
					rsp_line_q <= req.data;
				end else begin
					rsp_line_q <= mem[req.addr];
				end
			end else if (pending && !rsp_valid) begin
				if (wait_cnt == 2'd0) begin
					rsp_valid <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end else if (rsp_valid && rsp_ready) begin
				rsp_valid <= 1'b0;
				pending <= 1'b0;
			end
		end
	end

endmodule

// ==== serializer/line_serializer.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module line_serializer import line_dump_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  line_valid,
	output logic  line_ready,
	input  line_t line,
	output logic  byte_valid,
	input  logic  byte_ready,
	output byte_t byte_out,
	output logic  line_done
);

	localparam int IDX_W = $clog2(`LINE_BYTES);

	line_t line_q;
	logic [IDX_W-1:0] idx;
	logic active;
	logic last_xfer;

	assign line_ready = !active;
	assign byte_valid = active;
	assign byte_out = line_q[idx];

	assign last_xfer = active && byte_ready && (idx == IDX_W'(`LINE_BYTES - 1));

	always_ff @(posedge clk) begin
		if (line_valid && line_ready) begin
			line_q <= line;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			idx <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= last_xfer;
			if (line_valid && line_ready) begin
				active <= 1'b1;
				idx <= '0;
			end else if (last_xfer) begin
				active <= 1'b0;
			end else if (active && byte_ready) begin
				// stall here whenever the byte buffer is full
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

// ==== design/line_dump_top.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module line_dump_top import line_dump_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  write_req,
	input  logic                  read_req,
	input  logic [`ADDR_BITS-1:0] line_addr,
	output logic                  tx,
	output logic                  busy
);

	logic ctrl_req_valid;
	logic ctrl_req_ready;
	mem_req_t ctrl_req;
	logic store_req_valid;
	logic store_req_ready;
	mem_req_t store_req;
	logic rsp_valid;
	logic rsp_ready;
	mem_rsp_t rsp;
	logic line_valid;
	logic line_ready;
	line_t line;
	logic line_done;
	logic ser_byte_valid;
	logic ser_byte_ready;
	byte_t ser_byte;
	logic uart_byte_valid;
	logic uart_byte_ready;
	byte_t uart_byte;

	line_ctrl u_line_ctrl (
		.clk        (clk),
		.rst        (rst),
		.write_req  (write_req),
		.read_req   (read_req),
		.line_addr  (line_addr),
		.busy       (busy),
		.req_valid  (ctrl_req_valid),
		.req_ready  (ctrl_req_ready),
		.req        (ctrl_req),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp        (rsp),
		.line_valid (line_valid),
		.line_ready (line_ready),
		.line       (line),
		.line_done  (line_done)
	);

	// request buffer between the control and the line store
	stream_buffer #(.payload_t(mem_req_t)) u_req_buf (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (ctrl_req_valid),
		.in_ready  (ctrl_req_ready),
		.in_data   (ctrl_req),
		.out_valid (store_req_valid),
		.out_ready (store_req_ready),
		.out_data  (store_req)
	);

	line_store u_line_store (
		.clk       (clk),
		.rst       (rst),
		.req_valid (store_req_valid),
		.req_ready (store_req_ready),
		.req       (store_req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	line_serializer u_line_serializer (
		.clk        (clk),
		.rst        (rst),
		.line_valid (line_valid),
		.line_ready (line_ready),
		.line       (line),
		.byte_valid (ser_byte_valid),
		.byte_ready (ser_byte_ready),
		.byte_out   (ser_byte),
		.line_done  (line_done)
	);

	// byte buffer soaks up the serializer while the UART is slow
	stream_buffer #(.payload_t(byte_t)) u_byte_buf (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (ser_byte_valid),
		.in_ready  (ser_byte_ready),
		.in_data   (ser_byte),
		.out_valid (uart_byte_valid),
		.out_ready (uart_byte_ready),
		.out_data  (uart_byte)
	);

	uart_tx #(.CLKS_PER_BIT(`CLKS_PER_BIT)) u_uart_tx (
		.clk        (clk),
		.rst        (rst),
		.byte_valid (uart_byte_valid),
		.byte_ready (uart_byte_ready),
		.byte_in    (uart_byte),
		.tx         (tx)
	);

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_NS = 20
) (
	output logic clk
);

	// 40 ns period with the default half period
	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

endmodule

// ==== verif/line_dump_assert.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module line_dump_assert import line_dump_pkg::*; (
	input logic                  clk,
	input logic                  rst,
	input logic                  write_req,
	input logic                  read_req,
	input logic [`ADDR_BITS-1:0] line_addr,
	input logic                  busy,
	input logic                  tx
);

	localparam int CPB = `CLKS_PER_BIT;
	localparam int FRAME = 10 * CPB;
	localparam int LINES = 1 << `ADDR_BITS;

	line_t model [LINES];
	logic [LINES-1:0] written;
	byte_t exp_byte [256];
	logic exp_zero [256];
	logic [7:0] wr_ptr;
	logic [7:0] rd_ptr;
	int pending;
	int fail_count = 0;
	logic read_seen;
	logic rst_q;
	logic tx_q;
	logic in_frame;
	int off;
	int bit_num;
	byte_t rx_shift;
	logic accept;
	logic mid;
	logic stop_mid;
	byte_t head_byte;
	logic head_zero;

	// mirror of the control's acceptance rule where a write beats a read
	assign accept = !rst && !busy && (write_req || read_req);
	assign pending = int'(8'(wr_ptr - rd_ptr));
	assign bit_num = off / CPB;
	assign mid = in_frame && (off % CPB == CPB / 2);
	assign stop_mid = mid && (bit_num == 9);
	assign head_byte = exp_byte[rd_ptr];
	assign head_zero = exp_zero[rd_ptr];

	// each accepted read queues the sixteen bytes the UART should send
	always_ff @(posedge clk) begin
		if (rst) begin
			written <= '0;
			read_seen <= 1'b0;
			wr_ptr <= '0;
			for (int i = 0; i < LINES; i++) begin
				model[i] <= '0;
			end
		end else if (accept) begin
			if (write_req) begin
				written[line_addr] <= 1'b1;
				for (int k = 0; k < `LINE_BYTES; k++) begin
					model[line_addr][k] <= 8'(line_addr) ^ 8'(k);
				end
			end else begin
				read_seen <= 1'b1;
				for (int k = 0; k < `LINE_BYTES; k++) begin
					exp_byte[wr_ptr + 8'(k)] <= model[line_addr][k];
					exp_zero[wr_ptr + 8'(k)] <= !written[line_addr];
				end
				wr_ptr <= wr_ptr + 8'(`LINE_BYTES);
			end
		end
	end

	// offset 0 is the first low sample and bit b is sampled at b*CPB + CPB/2
	always_ff @(posedge clk) begin
		rst_q <= rst;
		tx_q <= tx;
		if (rst) begin
			in_frame <= 1'b0;
			off <= 0;
			rd_ptr <= '0;
		end else if (!in_frame) begin
			if (!tx) begin
				in_frame <= 1'b1;
				off <= 1;
			end
		end else begin
			off <= off + 1;
			if (mid && bit_num >= 1 && bit_num <= 8) begin
				rx_shift <= {tx, rx_shift[7:1]};
			end
			if (stop_mid) begin
				rd_ptr <= rd_ptr + 8'd1;
			end
			if (off == FRAME - 1) begin
				in_frame <= 1'b0;
			end
		end
	end

	a_reset_busy: assert property (@(posedge clk) disable iff (rst) rst_q && !rst |-> !busy)
		else begin
			$error("error at %0t: busy high right after reset", $time);
			fail_count++;
		end

	a_idle_high: assert property (@(posedge clk) disable iff (rst) !read_seen |-> tx)
		else begin
			$error("error at %0t: tx left idle before any read", $time);
			fail_count++;
		end

	a_bit_len: assert property (@(posedge clk) disable iff (rst)
		in_frame && (off % CPB != 0) |-> tx == tx_q)
		else begin
			$error("error at %0t: tx changed inside a bit time", $time);
			fail_count++;
		end

	a_start: assert property (@(posedge clk) disable iff (rst) mid && bit_num == 0 |-> !tx)
		else begin
			$error("error at %0t: start bit not low at its middle", $time);
			fail_count++;
		end

	a_stop: assert property (@(posedge clk) disable iff (rst) stop_mid |-> tx)
		else begin
			$error("error at %0t: stop bit low", $time);
			fail_count++;
		end

	a_extra: assert property (@(posedge clk) disable iff (rst) stop_mid |-> pending != 0)
		else begin
			$error("error at %0t: frame with no read waiting for it", $time);
			fail_count++;
		end

	a_data: assert property (@(posedge clk) disable iff (rst)
		stop_mid && pending != 0 |-> rx_shift == head_byte)
		else begin
			$error("error at %0t: byte %0d got %h, expected %h", $time,
				int'(rd_ptr) % `LINE_BYTES, rx_shift, head_byte);
			fail_count++;
		end

	a_unwritten: assert property (@(posedge clk) disable iff (rst)
		stop_mid && pending != 0 && head_zero |-> rx_shift == 8'h00)
		else begin
			$error("error at %0t: unwritten line gave byte %h", $time, rx_shift);
			fail_count++;
		end

endmodule

// ==== verif/line_dump_tb.sv ====
`timescale 1ns/1ps
`include "line_dump_params.svh"

module line_dump_tb;

	localparam int NUM_WR = 6;
	localparam int NUM_OPS = 2 * NUM_WR + 5;
	localparam int RST_CYCLES = 8;
	localparam int OP_CYCLES = `LINE_BYTES * 10 * `CLKS_PER_BIT + 64;
	localparam int LIMIT = NUM_OPS * OP_CYCLES + RST_CYCLES;
	localparam int SEED = 32'h18b69f6a;

	logic clk;
	logic rst;
	logic write_req;
	logic read_req;
	logic [`ADDR_BITS-1:0] line_addr;
	logic tx;
	logic busy;
	int cycles = 0;
	logic [`ADDR_BITS-1:0] wr_addr [NUM_WR];
	logic [(1 << `ADDR_BITS)-1:0] used;
	logic [`ADDR_BITS-1:0] free_addr;
	logic [`ADDR_BITS-1:0] poke_addr;

	tb_clock u_clock (
		.clk (clk)
	);

	line_dump_top DUT (
		.clk       (clk),
		.rst       (rst),
		.write_req (write_req),
		.read_req  (read_req),
		.line_addr (line_addr),
		.tx        (tx),
		.busy      (busy)
	);

	bind line_dump_top line_dump_assert u_assert (
		.clk       (clk),
		.rst       (rst),
		.write_req (write_req),
		.read_req  (read_req),
		.line_addr (line_addr),
		.busy      (busy),
		.tx        (tx)
	);

	// waits for the control to go idle, then gives a one-cycle request
	task automatic issue(input logic wr, input logic rd, input logic [`ADDR_BITS-1:0] addr);
		while (busy) @(negedge clk);
		write_req = wr;
		read_req = rd;
		line_addr = addr;
		@(negedge clk);
		write_req = 1'b0;
		read_req = 1'b0;
	endtask

	// random request pulses that the control must ignore
	task automatic poke_while_busy();
		while (busy) begin
			write_req = ($urandom % 3) == 0;
			read_req = ($urandom % 3) == 0;
			line_addr = `ADDR_BITS'($urandom);
			@(negedge clk);
		end
		write_req = 1'b0;
		read_req = 1'b0;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Done: errors found");
			$fatal(1, "timeout after %0d cycles", cycles);
		end
	end

	always @(negedge clk) begin
		if (DUT.u_assert.fail_count != 0) begin
			$display("Done: errors found");
			$fatal(1, "an assertion failed at %0t", $time);
		end
	end

	initial begin
		int dummy;
		rst = 1'b1;
		write_req = 1'b0;
		read_req = 1'b0;
		line_addr = '0;
		used = '0;
		dummy = $urandom(SEED);
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		for (int i = 0; i < NUM_WR; i++) begin
			wr_addr[i] = `ADDR_BITS'($urandom);
			used[wr_addr[i]] = 1'b1;
			issue(1'b1, 1'b0, wr_addr[i]);
		end
		// back to back reads keep the byte buffer full behind the UART
		for (int i = 0; i < NUM_WR; i++) begin
			issue(1'b0, 1'b1, wr_addr[i]);
		end

		free_addr = '0;
		for (int a = (1 << `ADDR_BITS) - 1; a >= 0; a--) begin
			if (!used[a]) free_addr = `ADDR_BITS'(a);
		end
		issue(1'b0, 1'b1, free_addr);

		poke_addr = wr_addr[NUM_WR - 1];
		issue(1'b1, 1'b0, poke_addr);
		poke_while_busy();
		issue(1'b0, 1'b1, poke_addr);
		poke_while_busy();

		// write and read together, the read back shows the write was taken
		issue(1'b1, 1'b1, free_addr);
		issue(1'b0, 1'b1, free_addr);

		while (busy) @(negedge clk);
		while (DUT.u_assert.pending != 0) @(negedge clk);
		repeat (2 * 10 * `CLKS_PER_BIT) @(negedge clk);

		if (DUT.u_assert.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "%0d assertion failures", DUT.u_assert.fail_count);
		end
	end

endmodule

// ==== line_dump_top.f ====
+incdir+common
common/line_dump_pkg.sv
design/stream_buffer.sv
design/uart_tx.sv
line_ctrl/line_ctrl.sv
line_store/line_store.sv
serializer/line_serializer.sv
design/line_dump_top.sv
verif/tb_clock.sv
verif/line_dump_assert.sv
verif/line_dump_tb.sv

// ==== Makefile ====
TOP = line_dump_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f line_dump_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f line_dump_top.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
